/* hdl/kbd_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard side constants
// scan byte and keycode widths and the
// AT prefix bytes seen on the PS/2 line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package kbd_pkg;

   // width of one scan byte from the keyboard.
   parameter int SCAN_W = 8;

   // width of one lisp-machine keycode.
   parameter int KEY_W = 8;

   // extended key prefix.
   parameter logic [SCAN_W-1:0] PREFIX_EXT = 8'hE0;

   // break prefix, the key was released.
   parameter logic [SCAN_W-1:0] PREFIX_BRK = 8'hF0;

endpackage

/* hdl/kbd_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard front end
// PS/2 receiver, converter, keycode FIFO
// and Wishbone host port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kbd_top
#(
   parameter int fifo_depth = 4
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ps2_clk,
   input  logic                     ps2_data,
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [wb_pkg::ADR_W-1:0] wb_adr,
   input  logic [wb_pkg::DAT_W-1:0] wb_dat_i,
   output logic [wb_pkg::DAT_W-1:0] wb_dat_o,
   output logic                     wb_ack,
   output logic                     irq
);

   logic                       code_strobe;
   logic [kbd_pkg::SCAN_W-1:0] code;
   logic                       parity_error;
   logic [kbd_pkg::SCAN_W:0]   rom_addr;
   logic [kbd_pkg::KEY_W-1:0]  rom_data;
   logic                       strobe_out;
   logic [kbd_pkg::KEY_W-1:0]  keycode;
   logic                       pop;
   logic                       clear_overflow;
   logic [kbd_pkg::KEY_W-1:0]  head;
   logic                       empty;
   logic [7:0]                 count;
   logic                       overflow;

   ps2_receiver u_receiver
   (
      .clk          (clk),
      .reset        (reset),
      .ps2_clk      (ps2_clk),
      .ps2_data     (ps2_data),
      .code_strobe  (code_strobe),
      .code         (code),
      .parity_error (parity_error)
   );

   scancode_convert u_convert
   (
      .clk        (clk),
      .reset      (reset),
      .strobe_in  (code_strobe),
      .code_in    (code),
      .rom_data   (rom_data),
      .rom_addr   (rom_addr),
      .strobe_out (strobe_out),
      .keycode    (keycode)
   );

   scancode_rom u_rom
   (
      .addr (rom_addr),
      .data (rom_data)
   );

   key_fifo #(.fifo_depth(fifo_depth)) u_fifo
   (
      .clk            (clk),
      .reset          (reset),
      .push           (strobe_out),
      .din            (keycode),
      .pop            (pop),
      .clear_overflow (clear_overflow),
      .head           (head),
      .empty          (empty),
      .count          (count),
      .overflow       (overflow)
   );

   wb_key_port u_port
   (
      .clk            (clk),
      .reset          (reset),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_i       (wb_dat_i),
      .head           (head),
      .empty          (empty),
      .count          (count),
      .overflow       (overflow),
      .parity_error   (parity_error),
      .wb_dat_o       (wb_dat_o),
      .wb_ack         (wb_ack),
      .pop            (pop),
      .clear_overflow (clear_overflow),
      .irq            (irq)
   );

endmodule

/* hdl/key_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keycode FIFO
// circular buffer with count and a sticky
// overflow flag for dropped writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module key_fifo
#(
   parameter int fifo_depth = 4
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      push,
   input  logic [kbd_pkg::KEY_W-1:0] din,
   input  logic                      pop,
   input  logic                      clear_overflow,
   output logic [kbd_pkg::KEY_W-1:0] head,
   output logic                      empty,
   output logic [7:0]                count,
   output logic                      overflow
);

   localparam int ptr_w = $clog2(fifo_depth);

   logic [kbd_pkg::KEY_W-1:0] mem [fifo_depth];
   logic [ptr_w-1:0]          wr_ptr;
   logic [ptr_w-1:0]          rd_ptr;
   logic                      full;
   logic                      do_push;
   logic                      do_pop;

   assign empty   = (count == 8'd0);
   assign full    = (count == 8'(fifo_depth));
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= 8'd0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + ptr_w'(1);
         if (do_pop)
            rd_ptr <= rd_ptr + ptr_w'(1);
         if (do_push && !do_pop)
            count <= count + 8'd1;
         else if (do_pop && !do_push)
            count <= count - 8'd1;
         // a dropped key wins over a clear in the same cycle.
         if (push && full)
            overflow <= 1'b1;
         else if (clear_overflow)
            overflow <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

endmodule

/* hdl/ps2_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 receiver
// deserializes 11-bit keyboard frames and
// checks start, odd parity and stop bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ps2_receiver
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       ps2_clk,
   input  logic                       ps2_data,
   output logic                       code_strobe,
   output logic [kbd_pkg::SCAN_W-1:0] code,
   output logic                       parity_error
);

   localparam logic [3:0] last_bit = 4'd10;

   logic [1:0]                 clk_sync;
   logic [1:0]                 data_sync;
   logic                       clk_prev;
   logic                       fall;
   logic [3:0]                 bit_cnt;
   // data bits in the low byte, parity in the top bit.
   logic [kbd_pkg::SCAN_W:0]   shift;
   logic                       frame_ok;

   assign fall = clk_prev & ~clk_sync[1];

   // data bits and parity must hold an odd number of ones.
   assign frame_ok = (^shift) & data_sync[1];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // synchronizers and edge detect
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bit counter and frame check
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bit_cnt      <= 4'd0;
         code_strobe  <= 1'b0;
         parity_error <= 1'b0;
      end
      else
      begin
         code_strobe  <= 1'b0;
         parity_error <= 1'b0;
         if (fall)
         begin
            // a high level at bit 0 is no start bit, so wait for one.
            if (bit_cnt == last_bit)
            begin
               bit_cnt      <= 4'd0;
               code_strobe  <= frame_ok;
               parity_error <= ~frame_ok;
            end
            else if (bit_cnt != 4'd0 || !data_sync[1])
               bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (fall && bit_cnt != last_bit)
         shift <= {data_sync[1], shift[kbd_pkg::SCAN_W:1]};
      if (fall && bit_cnt == last_bit)
         code <= shift[kbd_pkg::SCAN_W-1:0];
   end

endmodule

/* hdl/scancode_convert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan code converter
// prefix FSM turning AT scan sequences
// into lisp-machine keycode strobes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scancode_convert
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       strobe_in,
   input  logic [kbd_pkg::SCAN_W-1:0] code_in,
   input  logic [kbd_pkg::KEY_W-1:0]  rom_data,
   output logic [kbd_pkg::SCAN_W:0]   rom_addr,
   output logic                       strobe_out,
   output logic [kbd_pkg::KEY_W-1:0]  keycode
);

   localparam logic [2:0] IDLE    = 3'd0;
   localparam logic [2:0] EXT     = 3'd1;
   localparam logic [2:0] BRK     = 3'd2;
   localparam logic [2:0] RELEASE = 3'd3;
   localparam logic [2:0] CONVERT = 3'd4;
   localparam logic [2:0] STROBE  = 3'd5;

   logic [2:0]                 state;
   logic [2:0]                 next_state;
   logic                       ext_flag;
   logic                       brk_flag;
   logic [kbd_pkg::SCAN_W-1:0] sc;

   assign rom_addr   = {ext_flag, sc};
   assign strobe_out = (state == STROBE);

   // prefix states last one cycle and leave their flag behind.
   always_comb
   begin
      next_state = IDLE;
      case (state)
         IDLE:
         begin
            next_state = IDLE;
            if (strobe_in)
            begin
               if (code_in == kbd_pkg::PREFIX_EXT)
                  next_state = EXT;
               else if (code_in == kbd_pkg::PREFIX_BRK)
                  next_state = BRK;
               else if (brk_flag)
                  next_state = RELEASE;
               else
                  next_state = CONVERT;
            end
         end
         CONVERT: next_state = STROBE;
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= IDLE;
         ext_flag <= 1'b0;
         brk_flag <= 1'b0;
      end
      else
      begin
         state <= next_state;
         if (state == EXT)
            ext_flag <= 1'b1;
         if (state == BRK)
            brk_flag <= 1'b1;
         // a release or a converted key ends the sequence.
         if (state == RELEASE || state == CONVERT)
         begin
            ext_flag <= 1'b0;
            brk_flag <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == IDLE && strobe_in)
         sc <= code_in;
      if (state == CONVERT)
         keycode <= rom_data;
   end

endmodule

/* hdl/scancode_rom.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan code table
// maps {extended, scan byte} to keycode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scancode_rom
(
   input  logic [kbd_pkg::SCAN_W:0]  addr,
   output logic [kbd_pkg::KEY_W-1:0] data
);

   always_comb
   begin
      case (addr)
         // plain make codes.
         {1'b0, 8'h1C}: data = 8'd23;
         {1'b0, 8'h32}: data = 8'd24;
         {1'b0, 8'h21}: data = 8'd25;
         // return
         {1'b0, 8'h5A}: data = 8'd46;
         // space
         {1'b0, 8'h29}: data = 8'd77;
         // left shift
         {1'b0, 8'h12}: data = 8'd3;

         // E0 prefixed keys, the arrows and the left gui key.
         {1'b1, 8'h75}: data = 8'd106;
         {1'b1, 8'h72}: data = 8'd66;
         {1'b1, 8'h1F}: data = 8'd51;

         default:       data = '0;
      endcase
   end

endmodule

/* hdl/wb_key_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone key port
// data and status registers for the host,
// sticky error flags and the interrupt.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_key_port
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [wb_pkg::ADR_W-1:0]  wb_adr,
   input  logic [wb_pkg::DAT_W-1:0]  wb_dat_i,
   input  logic [kbd_pkg::KEY_W-1:0] head,
   input  logic                      empty,
   input  logic [7:0]                count,
   input  logic                      overflow,
   input  logic                      parity_error,
   output logic [wb_pkg::DAT_W-1:0]  wb_dat_o,
   output logic                      wb_ack,
   output logic                      pop,
   output logic                      clear_overflow,
   output logic                      irq
);

   logic                     request;
   logic                     clear_parity;
   logic                     parity_sticky;
   logic [wb_pkg::DAT_W-1:0] status_word;

   // the ack cycle itself is never a new request.
   assign request = wb_cyc & wb_stb & ~wb_ack;

   assign pop = request & ~wb_we & (wb_adr == wb_pkg::REG_DATA) & ~empty;
   assign clear_overflow = request & wb_we & (wb_adr == wb_pkg::REG_STATUS)
                           & wb_dat_i[wb_pkg::ST_OVERFLOW];
   assign clear_parity   = request & wb_we & (wb_adr == wb_pkg::REG_STATUS)
                           & wb_dat_i[wb_pkg::ST_PARITY];

   assign irq = ~empty;

   always_comb
   begin
      status_word = '0;
      status_word[wb_pkg::ST_NONEMPTY] = ~empty;
      status_word[wb_pkg::ST_PARITY]   = parity_sticky;
      status_word[wb_pkg::ST_OVERFLOW] = overflow;
      status_word[wb_pkg::ST_COUNT_LO +: 8] = count;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_ack        <= 1'b0;
         parity_sticky <= 1'b0;
      end
      else
      begin
         wb_ack <= request;
         if (parity_error)
            parity_sticky <= 1'b1;
         else if (clear_parity)
            parity_sticky <= 1'b0;
      end
   end

   // read data is captured on the same edge that pops the FIFO.
   always_ff @(posedge clk)
   begin
      if (request && !wb_we)
      begin
         if (wb_adr == wb_pkg::REG_STATUS)
            wb_dat_o <= status_word;
         else if (wb_adr == wb_pkg::REG_DATA && !empty)
            wb_dat_o <= wb_pkg::DAT_W'(head);
         else
            wb_dat_o <= '0;
      end
   end

endmodule

/* hdl/wb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus constants
// widths, register map and status bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wb_pkg;

   parameter int ADR_W = 2;
   parameter int DAT_W = 16;

   parameter logic [ADR_W-1:0] REG_DATA   = 2'd0;
   parameter logic [ADR_W-1:0] REG_STATUS = 2'd1;

   // status word layout, the count sits in the upper byte.
   parameter int ST_NONEMPTY = 0;
   parameter int ST_PARITY   = 1;
   parameter int ST_OVERFLOW = 2;
   parameter int ST_COUNT_LO = 8;

endpackage

/* list.f */
hdl/kbd_pkg.sv
hdl/wb_pkg.sv
hdl/ps2_receiver.sv
hdl/scancode_convert.sv
hdl/scancode_rom.sv
hdl/key_fifo.sv
hdl/wb_key_port.sv
hdl/kbd_top.sv
verification/kbd_assert.sv
verification/kbd_tb.sv

/* verification/kbd_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard front end assertions
// bus ack, keycode strobe and FIFO bound.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kbd_assert
#(
   parameter int fifo_depth = 4
)
(
   input logic       clk,
   input logic       reset,
   input logic       wb_cyc,
   input logic       wb_stb,
   input logic       wb_ack,
   input logic       strobe_out,
   input logic [7:0] count
);

   int fail_count = 0;

   // an ack answers the request seen on the edge before.
   assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
      else
      begin
         $error("wb_ack without a request in the previous cycle");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (reset)
      strobe_out |=> !strobe_out)
      else
      begin
         $error("strobe_out stayed high for two cycles");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (reset)
      count <= 8'(fifo_depth))
      else
      begin
         $error("FIFO count is above the FIFO depth");
         fail_count++;
      end

endmodule

bind kbd_top kbd_assert #(.fifo_depth(fifo_depth)) u_assert
(
   .clk        (clk),
   .reset      (reset),
   .wb_cyc     (wb_cyc),
   .wb_stb     (wb_stb),
   .wb_ack     (wb_ack),
   .strobe_out (strobe_out),
   .count      (count)
);

/* verification/kbd_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard front end testbench
// sends PS/2 frames and reads keycodes
// and status over Wishbone.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kbd_tb;

   localparam int fifo_depth = 4;
   localparam int rows       = 15;
   // rows 0 to 8 hold make codes with a listed keycode.
   localparam int keyed_rows = 9;

   logic                     clk;
   logic                     reset;
   logic                     ps2_clk;
   logic                     ps2_data;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [wb_pkg::ADR_W-1:0] wb_adr;
   logic [wb_pkg::DAT_W-1:0] wb_dat_i;
   logic [wb_pkg::DAT_W-1:0] wb_dat_o;
   logic                     wb_ack;
   logic                     irq;

   // up to three scan bytes per row, the first one in the top byte.
   logic [23:0] seq_tab [rows];
   int          len_tab [rows];
   bit          bad_tab [rows];
   int          key_tab [rows];
   integer      seed;
   int          expected [$];

   kbd_top #(.fifo_depth(fifo_depth)) uut
   (
      .clk      (clk),
      .reset    (reset),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .irq      (irq)
   );

   always #50 clk = ~clk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   always @(negedge clk)
   begin
      assert (uut.u_assert.fail_count == 0)
      else abort_run("a bound assertion on the DUT failed");
   end

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp)
      else abort_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic set_row(input int idx, input int len, input logic [23:0] seq,
                          input bit bad, input int key);
      seq_tab[idx] = seq;
      len_tab[idx] = len;
      bad_tab[idx] = bad;
      key_tab[idx] = key;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // PS/2 line driver
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic send_frame(input logic [7:0] b, input bit bad_parity);
      logic [10:0] frame;
      frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
      for (int k = 0; k < 11; k++)
      begin
         @(negedge clk);
         ps2_data = frame[k];
         repeat (6) @(negedge clk);
         ps2_clk = 1'b0;
         repeat (6) @(negedge clk);
         ps2_clk = 1'b1;
      end
   endtask

   task automatic send_row(input int row);
      for (int k = 0; k < len_tab[row]; k++)
      begin
         send_frame(seq_tab[row][23 - 8 * k -: 8], bad_tab[row]);
         repeat (12) @(negedge clk);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wishbone master
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic bus_cycle(input logic we, input logic [wb_pkg::ADR_W-1:0] adr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_i = wdata;
      @(negedge clk);
      while (!wb_ack && waited < 20)
      begin
         @(negedge clk);
         waited++;
      end
      assert (wb_ack === 1'b1) else abort_run("no wb_ack within 20 cycles of a request");
      rdata  = wb_dat_o;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_reg(input logic [wb_pkg::ADR_W-1:0] adr, output logic [15:0] rdata);
      bus_cycle(1'b0, adr, 16'd0, rdata);
   endtask

   task automatic write_reg(input logic [wb_pkg::ADR_W-1:0] adr, input logic [15:0] wdata);
      logic [15:0] unused;
      bus_cycle(1'b1, adr, wdata, unused);
   endtask

   task automatic wait_irq(input logic level);
      int waited;
      waited = 0;
      while (irq !== level && waited < 400)
      begin
         @(negedge clk);
         waited++;
      end
      assert (irq === level) else abort_run("irq did not reach the expected level in time");
   endtask

   task automatic wait_status(input logic [15:0] mask, input logic [15:0] value);
      logic [15:0] st;
      int          tries;
      tries = 0;
      read_reg(wb_pkg::REG_STATUS, st);
      while ((st & mask) !== value && tries < 50)
      begin
         read_reg(wb_pkg::REG_STATUS, st);
         tries++;
      end
      assert ((st & mask) === value)
      else abort_run("status word never reached its expected value");
   endtask

   task automatic drain_expected();
      logic [15:0] rdata;
      while (expected.size() > 0)
      begin
         read_reg(wb_pkg::REG_DATA, rdata);
         check_value("wb_dat_o", rdata, 16'(expected.pop_front()));
      end
      check_value("irq", 16'(irq), 16'd0);
   endtask

   initial
   begin
      logic [15:0] rdata;
      int          pick;
      int          burst;
      clk      = 1'b0;
      reset    = 1'b1;
      ps2_clk  = 1'b1;
      ps2_data = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_i = '0;
      seed     = 32'h5092;

      // keycodes follow the lisp-machine table, -1 means nothing is queued.
      set_row(0, 1, 24'h1C0000, 1'b0, 23);
      set_row(1, 1, 24'h320000, 1'b0, 24);
      set_row(2, 1, 24'h210000, 1'b0, 25);
      set_row(3, 1, 24'h5A0000, 1'b0, 46);
      set_row(4, 1, 24'h290000, 1'b0, 77);
      set_row(5, 1, 24'h120000, 1'b0, 3);
      set_row(6, 2, 24'hE07500, 1'b0, 106);
      set_row(7, 2, 24'hE07200, 1'b0, 66);
      set_row(8, 2, 24'hE01F00, 1'b0, 51);
      set_row(9, 1, 24'h750000, 1'b0, 0);
      set_row(10, 2, 24'hE01C00, 1'b0, 0);
      set_row(11, 2, 24'hF01C00, 1'b0, -1);
      set_row(12, 3, 24'hE0F075, 1'b0, -1);
      set_row(13, 1, 24'h1C0000, 1'b1, -1);
      set_row(14, 1, 24'h320000, 1'b0, 24);

      repeat (4) @(negedge clk);
      reset = 1'b0;
      check_value("irq", 16'(irq), 16'd0);

      // each row is drained before the next one is sent.
      for (int i = 0; i < rows; i++)
      begin
         send_row(i);
         if (key_tab[i] >= 0)
         begin
            wait_irq(1'b1);
            read_reg(wb_pkg::REG_DATA, rdata);
            check_value("wb_dat_o", rdata, 16'(key_tab[i]));
            check_value("irq", 16'(irq), 16'd0);
         end
         else
         begin
            read_reg(wb_pkg::REG_STATUS, rdata);
            check_value("status count", 16'(rdata[15:8]), 16'd0);
            check_value("irq", 16'(irq), 16'd0);
            check_value("status parity", 16'(rdata[wb_pkg::ST_PARITY]), 16'(bad_tab[i]));
            if (bad_tab[i])
            begin
               write_reg(wb_pkg::REG_STATUS, 16'(1 << wb_pkg::ST_PARITY));
               read_reg(wb_pkg::REG_STATUS, rdata);
               check_value("status parity", 16'(rdata[wb_pkg::ST_PARITY]), 16'd0);
            end
         end
      end

      // a random burst of make codes, read back in order.
      burst = 1 + ($unsigned($random(seed)) % fifo_depth);
      for (int j = 0; j < burst; j++)
      begin
         pick = $unsigned($random(seed)) % keyed_rows;
         send_row(pick);
         expected.push_back(key_tab[pick]);
         wait_status(16'hFF00, 16'((j + 1) << 8));
      end
      drain_expected();

      // two keys beyond the FIFO depth are dropped.
      for (int j = 0; j < fifo_depth + 2; j++)
      begin
         send_row(j % keyed_rows);
         if (j < fifo_depth)
         begin
            expected.push_back(key_tab[j % keyed_rows]);
            wait_status(16'hFF00, 16'((j + 1) << 8));
         end
      end
      wait_status(16'(1 << wb_pkg::ST_OVERFLOW), 16'(1 << wb_pkg::ST_OVERFLOW));
      read_reg(wb_pkg::REG_STATUS, rdata);
      check_value("status word", rdata,
                  16'((fifo_depth << 8) | (1 << wb_pkg::ST_OVERFLOW)
                      | (1 << wb_pkg::ST_NONEMPTY)));
      drain_expected();
      write_reg(wb_pkg::REG_STATUS, 16'(1 << wb_pkg::ST_OVERFLOW));
      read_reg(wb_pkg::REG_STATUS, rdata);
      check_value("status overflow", 16'(rdata[wb_pkg::ST_OVERFLOW]), 16'd0);

      read_reg(wb_pkg::REG_DATA, rdata);
      check_value("wb_dat_o", rdata, 16'd0);
      read_reg(wb_pkg::REG_STATUS, rdata);
      check_value("status word", rdata, 16'd0);

      if (uut.u_assert.fail_count == 0)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
         abort_run("a bound assertion on the DUT failed");
   end

endmodule
